//--- fx_fir.f
logic/fx_format_pkg.sv
logic/fir_stream_pkg.sv
logic/frac_mult.sv
logic/stream_stage.sv
logic/tap_delay_line.sv
logic/sat_adder_tree.sv
logic/fx_fir.sv
verif/fx_fir_properties.sv
verif/fx_fir_tb.sv

//--- logic/fir_stream_pkg.sv
package fir_stream_pkg;

  import fx_format_pkg::*;

  // one sample on a valid/ready stream, last marks the end of a frame
  typedef struct packed {
    logic    last;
    sample_t data;
  } sample_beat_t;

endpackage

//--- logic/frac_mult.sv
`timescale 1ns/10ps

module frac_mult #(
  parameter int A_W      = 16,
  parameter int B_W      = 16,
  parameter int OUT_W    = 18,
  parameter int FRAC_A   = 8,
  parameter int FRAC_B   = 14,
  parameter int FRAC_OUT = 8
) (
  input  logic signed [A_W-1:0]   a,
  input  logic signed [B_W-1:0]   b,
  output logic signed [OUT_W-1:0] result
);

  // number of fraction bits that fall off below the output binary point
  localparam int DROP = FRAC_A + FRAC_B - FRAC_OUT;

  logic signed [A_W+B_W-1:0] full_prod;

  assign full_prod = a * b;                     // full precision, both operands signed

  // taking a slice truncates toward minus infinity
  assign result = full_prod[DROP +: OUT_W];

endmodule

//--- logic/fx_fir.sv
`timescale 1ns/10ps

module fx_fir
  import fx_format_pkg::*, fir_stream_pkg::*;
#(
  parameter int NUM_TAPS = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  sample_beat_t         in_beat,
  output logic                 out_valid,
  input  logic                 out_ready,
  output sample_beat_t         out_beat,
  input  coef_t [NUM_TAPS-1:0] coefs
);

  typedef struct packed {
    sample_t [NUM_TAPS-1:0] samples;
    logic                   last;
  } win_t;

  typedef struct packed {
    acc_t [NUM_TAPS-1:0] products;
    logic                last;
  } prod_t;

  win_t                win;
  logic                win_valid;
  logic                win_ready;
  acc_t [NUM_TAPS-1:0] products;
  prod_t               prod_d;
  prod_t               prod_q;
  logic                prod_valid;
  logic                prod_ready;
  sample_t             sum;
  sample_beat_t        sum_beat;
  logic                sat_pos;    // watched by the bound properties
  logic                sat_neg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tap window
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  tap_delay_line #(.NUM_TAPS(NUM_TAPS)) u_delay (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
    .win_valid(win_valid), .win_ready(win_ready),
    .win_samples(win.samples), .win_last(win.last)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // multipliers and product register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar i = 0; i < NUM_TAPS; i++) begin : g_mult
    frac_mult #(
      .A_W(SAMPLE_W), .B_W(COEF_W), .OUT_W(ACC_W),
      .FRAC_A(SAMPLE_FRAC), .FRAC_B(COEF_FRAC), .FRAC_OUT(ACC_FRAC)
    ) u_mult (
      .a(win.samples[i]), .b(coefs[i]), .result(products[i])
    );
  end

  assign prod_d = '{products: products, last: win.last};

  stream_stage #(.T(prod_t)) stage_prod (
    .clk(clk), .rst(rst),
    .up_valid(win_valid), .up_ready(win_ready), .up_data(prod_d),
    .down_valid(prod_valid), .down_ready(prod_ready), .down_data(prod_q)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sum, saturate and output register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  sat_adder_tree #(.NUM_TAPS(NUM_TAPS)) u_sum (
    .products(prod_q.products), .sum(sum),
    .overflow_pos(sat_pos), .overflow_neg(sat_neg)
  );

  assign sum_beat = '{last: prod_q.last, data: sum};

  stream_stage #(.T(sample_beat_t)) stage_out (
    .clk(clk), .rst(rst),
    .up_valid(prod_valid), .up_ready(prod_ready), .up_data(sum_beat),
    .down_valid(out_valid), .down_ready(out_ready), .down_data(out_beat)
  );

endmodule

//--- logic/fx_format_pkg.sv
package fx_format_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sample format Q8.8
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int SAMPLE_W    = 16;
  localparam int SAMPLE_FRAC = 8;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // coefficient format Q2.14
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int COEF_W    = 16;
  localparam int COEF_FRAC = 14;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // aligned product format Q10.8
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int ACC_W    = 18;
  localparam int ACC_FRAC = 8;   // same binary point as the samples

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [COEF_W-1:0]   coef_t;
  typedef logic signed [ACC_W-1:0]    acc_t;

endpackage

//--- logic/sat_adder_tree.sv
`timescale 1ns/10ps

module sat_adder_tree
  import fx_format_pkg::*;
#(
  parameter int NUM_TAPS = 4
) (
  input  acc_t [NUM_TAPS-1:0] products,
  output sample_t             sum,
  output logic                overflow_pos,
  output logic                overflow_neg
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tree shape and growth
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int LEVELS = (NUM_TAPS > 1) ? $clog2(NUM_TAPS) : 1;
  localparam int LEAVES = 2 ** LEVELS;
  localparam int SUM_W  = ACC_W + LEVELS;       // one extra bit per level of adders
  localparam int MAX_I  = 2 ** (SAMPLE_W - 1) - 1;
  localparam int MIN_I  = -(2 ** (SAMPLE_W - 1));

  // heap layout, node n adds children 2n+1 and 2n+2, the root is node 0
  logic signed [SUM_W-1:0] node [0:2*LEAVES-2];
  logic signed [SUM_W-1:0] root;

  for (genvar i = 0; i < LEAVES; i++) begin : g_leaf
    if (i < NUM_TAPS) begin : g_used
      assign node[LEAVES-1+i] = SUM_W'($signed(products[i]));
    end else begin : g_pad
      assign node[LEAVES-1+i] = '0;           // unused leaves pad the tree to a power of two
    end
  end

  for (genvar n = 0; n < LEAVES - 1; n++) begin : g_node
    assign node[n] = node[2*n+1] + node[2*n+2];
  end

  assign root = node[0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // clamp to the sample range
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign overflow_pos = (root > MAX_I);
  assign overflow_neg = (root < MIN_I);

  always_comb begin
    if (overflow_pos) begin
      sum = {1'b0, {(SAMPLE_W-1){1'b1}}};
    end else if (overflow_neg) begin
      sum = {1'b1, {(SAMPLE_W-1){1'b0}}};
    end else begin
      sum = root[SAMPLE_W-1:0];             // fraction bits already line up
    end
  end

endmodule

//--- logic/stream_stage.sv
`timescale 1ns/10ps

module stream_stage #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic up_valid,
  output logic up_ready,
  input  T     up_data,
  output logic down_valid,
  input  logic down_ready,
  output T     down_data
);

  logic valid_q;
  T     data_q;

  // free slot now or the held beat leaves on this edge
  assign up_ready = !valid_q || down_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (up_ready) begin
      valid_q <= up_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (up_valid && up_ready) begin
      data_q <= up_data;
    end
  end

  assign down_valid = valid_q;
  assign down_data  = data_q;

endmodule

//--- logic/tap_delay_line.sv
`timescale 1ns/10ps

module tap_delay_line
  import fx_format_pkg::*, fir_stream_pkg::*;
#(
  parameter int NUM_TAPS = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  sample_beat_t           in_beat,
  output logic                   win_valid,
  input  logic                   win_ready,
  output sample_t [NUM_TAPS-1:0] win_samples,
  output logic                   win_last
);

  sample_t [NUM_TAPS-1:0] taps_q;   // tap 0 holds the newest sample
  logic                   last_q;
  logic                   valid_q;
  logic                   run_q;    // low while in reset, so no beat is taken then

  assign in_ready = run_q && (!valid_q || win_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      run_q   <= 1'b0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
      taps_q  <= '0;                // older taps read as zero after reset
    end else begin
      run_q <= 1'b1;
      if (in_valid && in_ready) begin
        for (int i = NUM_TAPS - 1; i > 0; i--) begin
          taps_q[i] <= taps_q[i-1];
        end
        taps_q[0] <= in_beat.data;
        last_q    <= in_beat.last;
        valid_q   <= 1'b1;
      end else if (win_ready) begin
        valid_q <= 1'b0;            // window taken and nothing new came in
      end
    end
  end

  assign win_valid   = valid_q;
  assign win_samples = taps_q;
  assign win_last    = last_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fx_fir testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
  --top-module fx_fir_tb \
  -Mdir obj_dir \
  -f fx_fir.f

# a failed assertion stops the model, the search below decides the result
sim_output=$(./obj_dir/Vfx_fir_tb 2>&1) || true
echo "$sim_output"

if echo "$sim_output" | grep -q "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi

//--- verif/fx_fir_properties.sv
`timescale 1ns/10ps

module fx_fir_properties
  import fx_format_pkg::*, fir_stream_pkg::*;
#(
  parameter int NUM_TAPS = 4
) (
  input logic                    clk,
  input logic                    rst,
  input logic                    out_valid,
  input logic                    out_ready,
  input sample_beat_t            out_beat,
  input logic                    prod_valid,
  input logic                    prod_ready,
  input logic [NUM_TAPS*ACC_W:0] prod_data,  // product struct seen as flat bits
  input logic                    sat_pos,
  input logic                    sat_neg
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reset behavior of the output stream
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  out_idle_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high while in reset");

  out_idle_after_reset: assert property (@(posedge clk) $fell(rst) |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // a stalled beat holds still until it moves
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("output beat changed while stalled");

  prod_hold: assert property (@(posedge clk) disable iff (rst)
    prod_valid && !prod_ready |=> prod_valid && $stable(prod_data))
    else $error("product stage beat changed while stalled");

  // a flagged sum reaches the output register as one limit of the sample range only
  sat_pos_limit: assert property (@(posedge clk) disable iff (rst)
    prod_valid && prod_ready && sat_pos |=> out_beat.data == sample_t'(32767))
    else $error("positive overflow did not leave as the largest sample");

  sat_neg_limit: assert property (@(posedge clk) disable iff (rst)
    prod_valid && prod_ready && sat_neg |=> out_beat.data == sample_t'(-32768))
    else $error("negative overflow did not leave as the smallest sample");

endmodule

bind fx_fir fx_fir_properties #(.NUM_TAPS(NUM_TAPS)) u_properties (
  .clk(clk), .rst(rst),
  .out_valid(out_valid), .out_ready(out_ready), .out_beat(out_beat),
  .prod_valid(prod_valid), .prod_ready(prod_ready), .prod_data(prod_q),
  .sat_pos(sat_pos), .sat_neg(sat_neg)
);

//--- verif/fx_fir_tb.sv
`timescale 1ns/10ps

module fx_fir_tb
  import fx_format_pkg::*, fir_stream_pkg::*;
;

  localparam int TAPS      = 4;
  localparam int WAIT_MAX  = 200;   // cycles any single wait may take

  logic               clk;
  logic               rst;
  logic               in_valid;
  logic               in_ready;
  sample_beat_t       in_beat;
  logic               out_valid;
  logic               out_ready;
  sample_beat_t       out_beat;
  coef_t [TAPS-1:0]   coefs;

  sample_beat_t exp_q[$];           // expected beats in output order
  int           stamp_q[$];         // cycle of the matching input handshake
  int           hist [TAPS];        // model history, newest sample at index 0
  int           cycle;
  bit           random_ready;
  bit           check_latency;
  int           value_errors;
  int           latency_errors;
  int           extra_outputs;
  int           timeouts;

  fx_fir #(.NUM_TAPS(TAPS)) dut (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_ready(in_ready), .in_beat(in_beat),
    .out_valid(out_valid), .out_ready(out_ready), .out_beat(out_beat),
    .coefs(coefs)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  always @(posedge clk) begin
    #1;
    if (random_ready) begin
      out_ready = ($urandom % 2) == 0;  // about half the cycles stall the output
    end else begin
      out_ready = 1'b1;
    end
  end

  // products drop 14 fraction bits, the sum is clamped to 16 bits
  function automatic sample_beat_t expected_beat(input logic last);
    int           acc;
    sample_beat_t beat;
    acc = 0;
    for (int i = 0; i < TAPS; i++) begin
      acc += (hist[i] * int'($signed(coefs[i]))) >>> 14;
    end
    if (acc > 32767) begin
      acc = 32767;
    end else if (acc < -32768) begin
      acc = -32768;
    end
    beat.last = last;
    beat.data = sample_t'(acc);
    return beat;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // monitor, sampled mid cycle where all signals are settled
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk) begin
    sample_beat_t want;
    int           stamp;
    if (rst) begin
      exp_q.delete();                 // in-flight beats die with the reset
      stamp_q.delete();
      foreach (hist[i]) hist[i] = 0;
    end else begin
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          extra_outputs++;
          $display("Output beat at %0t has no matching input", $time);
        end else begin
          want  = exp_q.pop_front();
          stamp = stamp_q.pop_front();
          assert (out_beat == want) else begin
            value_errors++;
            $display("Error at %0t: expected data %0d last %0b, got data %0d last %0b",
                     $time, want.data, want.last, out_beat.data, out_beat.last);
          end
          if (check_latency) begin
            assert (cycle - stamp == 3) else begin
              latency_errors++;
              $display("Error at %0t: latency %0d cycles, expected 3", $time, cycle - stamp);
            end
          end
        end
      end
      if (in_valid && in_ready) begin
        for (int i = TAPS - 1; i > 0; i--) begin
          hist[i] = hist[i-1];
        end
        hist[0] = int'(in_beat.data);
        exp_q.push_back(expected_beat(in_beat.last));
        stamp_q.push_back(cycle);
      end
    end
  end

  task automatic apply_reset();
    rst      = 1'b1;
    in_valid = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
  endtask

  task automatic send_beat(input sample_t data, input logic last);
    int waited;
    waited   = 0;
    in_valid = 1'b1;
    in_beat  = '{last: last, data: data};
    @(negedge clk);
    while (!in_ready) begin
      waited++;
      if (waited > WAIT_MAX) begin
        timeouts++;
        $display("Input beat was never accepted, gave up at %0t", $time);
        break;
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1 in_valid = 1'b0;
  endtask

  task automatic send_random(input int count, input bit gaps);
    for (int n = 0; n < count; n++) begin
      if (gaps && ($urandom % 2) == 0) begin
        @(posedge clk);                 // idle cycle with in_valid low
        #1;
      end
      send_beat(sample_t'($urandom), ($urandom % 8) == 0);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_MAX) begin
        timeouts++;
        $display("Expected outputs never arrived, %0d still missing", exp_q.size());
        break;
      end
    end
    repeat (4) @(posedge clk);
    #1;
  endtask

  initial begin
    int total;
    void'($urandom(78));
    rst = 1'b1;
    in_valid = 1'b0;
    in_beat = '0;
    out_ready = 1'b1;
    coefs = '0;
    cycle = 0;
    random_ready = 1'b0;
    check_latency = 1'b1;
    value_errors = 0;
    latency_errors = 0;
    extra_outputs = 0;
    timeouts = 0;
    apply_reset();

    // impulse of 1.0 reads the coefficients back shifted by 6
    coefs = {coef_t'(1000), coef_t'(4096), coef_t'(-8192), coef_t'(16384)};
    send_beat(sample_t'(256), 1'b1);
    repeat (TAPS) send_beat(sample_t'(0), 1'b0);
    drain();

    foreach (coefs[i]) coefs[i] = coef_t'($urandom);
    send_random(200, 1'b0);
    drain();

    coefs = {TAPS{coef_t'(32767)}};
    repeat (TAPS) send_beat(sample_t'(32767), 1'b0);
    repeat (TAPS) send_beat(sample_t'(-32768), 1'b1);
    drain();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // back-pressure, then a reset with beats still in flight
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    check_latency = 1'b0;
    random_ready = 1'b1;
    foreach (coefs[i]) coefs[i] = coef_t'($urandom);
    send_random(200, 1'b1);
    drain();
    send_random(20, 1'b0);
    apply_reset();
    send_random(50, 1'b1);
    drain();

    total = value_errors + latency_errors + extra_outputs + timeouts;
    $display("Checks done: %0d value errors, %0d latency errors, %0d unexpected outputs, %0d timeouts",
             value_errors, latency_errors, extra_outputs, timeouts);
    if (total == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
